// ==== include/rv_alu_defs.svh ====
`ifndef RV_ALU_DEFS_SVH
`define RV_ALU_DEFS_SVH

// Datapath width
`define RV_XLEN 32

// Major opcodes, instr[6:0]
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011

// funct3, instr[14:12]
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct7, instr[31:25]
`define RV_F7_BASE 7'b0000000
`define RV_F7_ALT  7'b0100000  // SUB and SRA/SRAI

// AXI4-Lite byte address width, five words mapped
`define RV_AXIL_AW 5

`endif

// ==== hdl/rv_alu_pkg.sv ====
`default_nettype none

`include "rv_alu_defs.svh"

package rv_alu_pkg;

    // ALU function, one per RV32I integer op
    typedef enum logic [3:0] {
        fn_add  = 4'd0,
        fn_sub  = 4'd1,
        fn_sll  = 4'd2,
        fn_slt  = 4'd3,
        fn_sltu = 4'd4,
        fn_xor  = 4'd5,
        fn_srl  = 4'd6,
        fn_sra  = 4'd7,
        fn_or   = 4'd8,
        fn_and  = 4'd9
    } alu_fn_e;

    // Decode to execute
    typedef struct packed {
        alu_fn_e              fn;
        logic [`RV_XLEN-1:0]  op_a;     // rs1
        logic [`RV_XLEN-1:0]  op_b;     // rs2 or sign-extended imm
        logic                 illegal;
        logic                 valid;
    } alu_op_t;

    // Execute to result
    typedef struct packed {
        logic [`RV_XLEN-1:0]  value;
        logic                 illegal;
        logic                 valid;
    } alu_res_t;

    // Word index of the host registers, byte address >> 2
    typedef enum logic [2:0] {
        reg_rs1    = 3'd0,  // 0x00
        reg_rs2    = 3'd1,  // 0x04
        reg_instr  = 3'd2,  // 0x08, write issues an op
        reg_result = 3'd3,  // 0x0C, RO
        reg_status = 3'd4   // 0x10, RO
    } alu_reg_e;

endpackage

`default_nettype wire

// ==== hdl/rv_alu_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module rv_alu_decode import rv_alu_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  logic [`RV_XLEN-1:0] instr,
    input  logic [`RV_XLEN-1:0] rs1,
    input  logic [`RV_XLEN-1:0] rs2,
    input  logic                issue,   // One-cycle start pulse
    output alu_op_t             op
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;     // I-type immediate, sign extended
    alu_fn_e             fn_d;
    logic [`RV_XLEN-1:0] op_b_d;
    logic                illegal_d;

    alu_fn_e             fn_q;
    logic [`RV_XLEN-1:0] op_a_q;
    logic [`RV_XLEN-1:0] op_b_q;
    logic                illegal_q;
    logic                valid_q;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];       // Also imm[11:5] of shift-immediates
    assign imm_i  = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        fn_d      = fn_add;                // Harmless default for illegal ops
        op_b_d    = rs2;
        illegal_d = 1'b0;
        case (opcode)
            `RV_OPC_OP: begin
                case (funct3)
                    `RV_F3_ADD_SUB: fn_d = (funct7 == `RV_F7_ALT) ? fn_sub : fn_add;
                    `RV_F3_SLL:     fn_d = fn_sll;
                    `RV_F3_SLT:     fn_d = fn_slt;
                    `RV_F3_SLTU:    fn_d = fn_sltu;
                    `RV_F3_XOR:     fn_d = fn_xor;
                    `RV_F3_SRL_SRA: fn_d = (funct7 == `RV_F7_ALT) ? fn_sra : fn_srl;
                    `RV_F3_OR:      fn_d = fn_or;
                    default:        fn_d = fn_and;
                endcase
                if (funct7 == `RV_F7_ALT) begin
                    // Alt form only exists for SUB and SRA
                    illegal_d = (funct3 != `RV_F3_ADD_SUB) && (funct3 != `RV_F3_SRL_SRA);
                end else if (funct7 != `RV_F7_BASE) begin
                    illegal_d = 1'b1;              // e.g. M extension
                end
            end
            `RV_OPC_OP_IMM: begin
                op_b_d = imm_i;                    // Shifts only look at [4:0]
                case (funct3)
                    `RV_F3_ADD_SUB: fn_d = fn_add;      // No SUBI
                    `RV_F3_SLL: begin
                        fn_d      = fn_sll;
                        illegal_d = (funct7 != `RV_F7_BASE);
                    end
                    `RV_F3_SLT:     fn_d = fn_slt;
                    `RV_F3_SLTU:    fn_d = fn_sltu;
                    `RV_F3_XOR:     fn_d = fn_xor;
                    `RV_F3_SRL_SRA: begin
                        fn_d      = (funct7 == `RV_F7_ALT) ? fn_sra : fn_srl;
                        illegal_d = (funct7 != `RV_F7_BASE) && (funct7 != `RV_F7_ALT);
                    end
                    `RV_F3_OR:      fn_d = fn_or;
                    default:        fn_d = fn_and;
                endcase
            end
            default: illegal_d = 1'b1;         // Loads, branches, LUI etc
        endcase
    end

    // Operand payload, captured on issue only
    always_ff @(posedge clk) begin
        if (issue) begin
            fn_q   <= fn_d;
            op_a_q <= rs1;
            op_b_q <= op_b_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= issue;
            illegal_q <= issue && illegal_d;
        end
    end

    assign op = '{fn: fn_q, op_a: op_a_q, op_b: op_b_q, illegal: illegal_q, valid: valid_q};

    // A legal op came from OP or OP-IMM, and SUB only from OP
    a_legal_src: assert property (@(posedge clk) disable iff (!arst_n)
        valid_q && !illegal_q |-> $past(opcode) inside {`RV_OPC_OP, `RV_OPC_OP_IMM});
    a_sub_op_only: assert property (@(posedge clk) disable iff (!arst_n)
        valid_q && !illegal_q && fn_q == fn_sub |-> $past(opcode) == `RV_OPC_OP);

endmodule

`default_nettype wire

// ==== hdl/rv_alu_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module rv_alu_execute import rv_alu_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  alu_op_t  op,
    output alu_res_t res
);

    logic [4:0]          shamt;       // Low five bits of op_b
    logic [`RV_XLEN-1:0] alu_val;
    logic [`RV_XLEN-1:0] value_q;
    logic                illegal_q;
    logic                valid_q;

    assign shamt = op.op_b[4:0];

    always_comb begin
        case (op.fn)
            fn_add:  alu_val = op.op_a + op.op_b;
            fn_sub:  alu_val = op.op_a - op.op_b;
            fn_sll:  alu_val = op.op_a << shamt;           // Zero fill
            fn_slt:  alu_val = ($signed(op.op_a) < $signed(op.op_b)) ? 32'd1 : 32'd0;
            fn_sltu: alu_val = (op.op_a < op.op_b) ? 32'd1 : 32'd0;
            fn_xor:  alu_val = op.op_a ^ op.op_b;
            fn_srl:  alu_val = op.op_a >> shamt;
            fn_sra:  alu_val = $unsigned($signed(op.op_a) >>> shamt);  // Sign fill
            fn_or:   alu_val = op.op_a | op.op_b;
            fn_and:  alu_val = op.op_a & op.op_b;
            default: alu_val = '0;                         // Unused enum codes
        endcase
    end

    // Result word, loaded only for a valid op
    always_ff @(posedge clk) begin
        if (op.valid) begin
            value_q <= op.illegal ? '0 : alu_val;          // Illegal reads back zero
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            valid_q   <= op.valid;
            illegal_q <= op.valid && op.illegal;
        end
    end

    assign res = '{value: value_q, illegal: illegal_q, valid: valid_q};

endmodule

`default_nettype wire

// ==== hdl/rv_alu_result.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module rv_alu_result import rv_alu_pkg::*; (
    input  logic                clk,
    input  logic                arst_n,
    input  alu_res_t            res,
    output logic [`RV_XLEN-1:0] result_value,   // Last completed value
    output logic                illegal_flag,   // Sticky until reset
    output logic [15:0]         done_count      // Wraps at 16 bits
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_value <= '0;
            illegal_flag <= 1'b0;
            done_count   <= '0;
        end else if (res.valid) begin
            result_value <= res.value;
            illegal_flag <= illegal_flag | res.illegal;
            done_count   <= done_count + 16'd1;
        end
    end

    // Count only moves after a valid result
    a_count_on_valid: assert property (@(posedge clk) disable iff (!arst_n)
        $changed(done_count) |-> $past(res.valid));

endmodule

`default_nettype wire

// ==== hdl/rv_alu_axil_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module rv_alu_axil_regs import rv_alu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`RV_AXIL_AW-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`RV_XLEN-1:0]    wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`RV_AXIL_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`RV_XLEN-1:0]    rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`RV_XLEN-1:0]    instr,
    output logic [`RV_XLEN-1:0]    rs1,
    output logic [`RV_XLEN-1:0]    rs2,
    output logic                   issue,
    input  logic [`RV_XLEN-1:0]    result_value,
    input  logic                   illegal_flag,
    input  logic [15:0]            done_count
);

    logic                wr_rdy_q;      // Shared AW/W ready pulse
    logic                wr_fire;
    logic                wr_en;         // Aligned full-word write
    logic                rd_fire;
    alu_reg_e            wr_reg;
    alu_reg_e            rd_reg;
    logic [`RV_XLEN-1:0] rd_data;

    assign awready = wr_rdy_q;
    assign wready  = wr_rdy_q;
    assign bresp   = 2'b00;             // Always OKAY
    assign rresp   = 2'b00;

    assign wr_fire = awvalid && awready && wvalid && wready;
    assign rd_fire = arvalid && arready;
    assign wr_reg  = alu_reg_e'(awaddr[4:2]);
    assign rd_reg  = alu_reg_e'(araddr[4:2]);
    assign wr_en   = wr_fire && (awaddr[1:0] == 2'b00) && (&wstrb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_rdy_q <= 1'b0;
            bvalid   <= 1'b0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            issue    <= 1'b0;
        end else begin
            wr_rdy_q <= awvalid && wvalid && !wr_rdy_q && !bvalid;  // Both valid, no B pending
            arready  <= arvalid && !arready && !rvalid;
            issue    <= wr_en && (wr_reg == reg_instr);
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Host registers; RO and unmapped writes fall through
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (wr_reg)
                reg_rs1:   rs1   <= wdata;
                reg_rs2:   rs2   <= wdata;
                reg_instr: instr <= wdata;   // issue follows from the same write
                default: ;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;                          // Unmapped and misaligned read zero
        if (araddr[1:0] == 2'b00) begin
            case (rd_reg)
                reg_rs1:    rd_data = rs1;
                reg_rs2:    rd_data = rs2;
                reg_instr:  rd_data = instr;
                reg_result: rd_data = result_value;
                reg_status: rd_data = {done_count, 15'd0, illegal_flag};
                default:    rd_data = '0;
            endcase
        end
    end

    // Read data held with rvalid
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_data;
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// ==== hdl/rv_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module rv_alu_top import rv_alu_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [`RV_AXIL_AW-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`RV_XLEN-1:0]    wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`RV_AXIL_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`RV_XLEN-1:0]    rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    logic [`RV_XLEN-1:0] instr;
    logic [`RV_XLEN-1:0] rs1;
    logic [`RV_XLEN-1:0] rs2;
    logic                issue;         // AXI block to decode
    alu_op_t             op;            // Decode to execute
    alu_res_t            res;           // Execute to result
    logic [`RV_XLEN-1:0] result_value;
    logic                illegal_flag;
    logic [15:0]         done_count;

    rv_alu_axil_regs i_axil_regs (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .instr, .rs1, .rs2, .issue,
        .result_value, .illegal_flag, .done_count
    );

    rv_alu_decode i_decode (
        .clk, .arst_n, .instr, .rs1, .rs2, .issue, .op
    );

    rv_alu_execute i_execute (
        .clk, .arst_n, .op, .res
    );

    rv_alu_result i_result (
        .clk, .arst_n, .res, .result_value, .illegal_flag, .done_count
    );

endmodule

`default_nettype wire

// ==== bench/tb_rv_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_alu_defs.svh"

module tb_rv_alu_top import rv_alu_pkg::*; ();

    localparam int WAIT_LIMIT = 64;     // Cycles per handshake
    localparam int POLL_LIMIT = 16;     // Status reads per operation

    logic                   clk;
    logic                   arst_n;
    logic [`RV_AXIL_AW-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`RV_AXIL_AW-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    logic [31:0] lfsr;                  // Stimulus generator state
    int          checks;
    int          errors;
    int          mark_checks;           // Counts at start of current test
    int          mark_errors;
    logic [15:0] exp_count;             // Model of the completion counter
    logic        exp_flag;              // Model of the sticky flag
    logic [31:0] exp_result;            // Model of the last result

    rv_alu_top i_dut (.*);

    always #20 clk = ~clk;              // 40 ns period

    // Galois LFSR x^32+x^22+x^2+x+1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Reference ALU straight from the RV32I rules
    function automatic alu_res_t model_op(input logic [31:0] ins, a, rs2_val);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        bad;
        logic        alt;
        logic [31:0] v;
        alu_res_t    r;
        opc = ins[6:0];
        f3  = ins[14:12];
        f7  = ins[31:25];
        alt = (f7 == 7'b0100000);
        b   = rs2_val;
        bad = 1'b1;                                     // Any other opcode
        if (opc == 7'b0110011) begin
            bad = !(f7 == 7'b0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
        end else if (opc == 7'b0010011) begin
            b   = {{20{ins[31]}}, ins[31:20]};
            bad = (f3 == 3'd1 && f7 != 7'b0) || (f3 == 3'd5 && !(f7 == 7'b0 || alt));
            alt = alt && (f3 == 3'd5);                  // No SUBI
        end
        sh = b[4:0];
        case (f3)
            3'd0:    v = alt ? a - b : a + b;
            3'd1:    v = a << sh;
            3'd2:    v = {31'd0, (a ^ 32'h80000000) < (b ^ 32'h80000000)};  // Signed via bias
            3'd3:    v = {31'd0, a < b};
            3'd4:    v = a ^ b;
            3'd5:    v = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'd0);
            3'd6:    v = a | b;
            default: v = a & b;
        endcase
        r.value   = bad ? 32'd0 : v;
        r.illegal = bad;
        r.valid   = 1'b1;
        return r;
    endfunction

    // Legal OP word for fn in enum order add..and
    function automatic logic [31:0] make_op(input int fn);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [9:0] regs;
        logic [4:0] rd;
        case (fn)
            0, 1:    f3 = 3'd0;                         // ADD, SUB
            2:       f3 = 3'd1;
            3:       f3 = 3'd2;
            4:       f3 = 3'd3;
            5:       f3 = 3'd4;
            6, 7:    f3 = 3'd5;                         // SRL, SRA
            8:       f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        f7   = (fn == 1 || fn == 7) ? 7'b0100000 : 7'b0000000;
        regs = 10'(rand_bits(10));                      // Register fields the DUT ignores
        rd   = 5'(rand_bits(5));
        return {f7, regs, f3, rd, 7'b0110011};
    endfunction

    // Legal OP-IMM word where every tenth pair forces shamt 0 or 31
    function automatic logic [31:0] make_opi(input int i);
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  sh;
        logic [4:0]  rs1f;
        logic [4:0]  rd;
        f3  = 3'(rand_bits(3));
        imm = 12'(rand_bits(12));                       // Upper bit set half the time
        sh  = 5'(rand_bits(5));
        if (i % 10 < 2) begin
            f3 = (i % 10 == 0) ? 3'd1 : 3'd5;
            sh = (i % 20 < 10) ? 5'd0 : 5'd31;
        end
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {(f3 == 3'd5 && rand_bits(1) == 32'd1) ? 7'b0100000 : 7'b0000000, sh};
        end
        rs1f = 5'(rand_bits(5));
        rd   = 5'(rand_bits(5));
        return {imm, rs1f, f3, rd, 7'b0010011};
    endfunction

    task automatic abort_on_timeout(input string msg);
        $display("Timeout at %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        checks = checks + 1;
        if (got !== want) begin
            errors = errors + 1;
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_flag(input logic got, input logic want, input string what);
        checks = checks + 1;
        if (got !== want) begin
            errors = errors + 1;
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_count(input logic [15:0] got, input logic [15:0] want,
                               input string what);
        checks = checks + 1;
        if (got !== want) begin
            errors = errors + 1;
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, want);
        end
    endtask

    // Starts and ends on a falling edge with bready held off for hold cycles
    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data, input int hold);
        int t;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;                                 // Full words only
        awvalid = 1'b1;
        wvalid  = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_on_timeout("awready/wready never rose for a write");
        end while (!(awready && wready));
        @(negedge clk);                                 // Transfer on the edge between
        awvalid = 1'b0;
        wvalid  = 1'b0;
        t = 0;
        while (!bvalid) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_on_timeout("bvalid never rose after a write");
        end
        repeat (hold) begin
            @(negedge clk);
            check_flag(bvalid, 1'b1, "bvalid held under back-pressure");
        end
        check_flag(bresp == 2'b00, 1'b1, "bresp OKAY");
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data, input int hold);
        int          t;
        logic [31:0] first;
        araddr  = addr;
        arvalid = 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_on_timeout("arready never rose for a read");
        end while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        t = 0;
        while (!rvalid) begin
            @(negedge clk);
            t++;
            if (t > WAIT_LIMIT) abort_on_timeout("rvalid never rose after a read");
        end
        first = rdata;
        repeat (hold) begin
            @(negedge clk);
            check_flag(rvalid, 1'b1, "rvalid held under back-pressure");
            check_value(rdata, first, "rdata stable under back-pressure");
        end
        check_flag(rresp == 2'b00, 1'b1, "rresp OKAY");
        data   = first;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_count(input logic [15:0] target);
        int          t;
        logic [31:0] st;
        t = 0;
        axil_read(5'h10, st, 0);
        while (st[31:16] != target) begin
            t++;
            if (t > POLL_LIMIT) abort_on_timeout("completion count never reached its target");
            axil_read(5'h10, st, 0);
        end
    endtask

    // One issued operation polled to completion and checked
    task automatic run_op(input logic [31:0] ins, input logic [31:0] a, input logic [31:0] b);
        alu_res_t    want;
        logic [31:0] rd;
        axil_write(5'h00, a, 0);
        axil_write(5'h04, b, 0);
        axil_write(5'h08, ins, 0);
        want       = model_op(ins, a, b);
        exp_count  = exp_count + 16'd1;
        exp_flag   = exp_flag | want.illegal;
        exp_result = want.value;
        wait_count(exp_count);
        axil_read(5'h0C, rd, 0);
        check_value(rd, want.value, $sformatf("result of %h", ins));
        axil_read(5'h10, rd, 0);
        check_flag(rd[0], exp_flag, "sticky illegal flag");
        check_count(rd[31:16], exp_count, "completion count");
        check_value({17'd0, rd[15:1]}, 32'd0, "status reserved bits");
    endtask

    task automatic report_test(input string name);
        $display("Test %-10s %0d checks, %0d errors", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        logic [31:0] ins;
        int          hold;
        alu_res_t    want;
        clk         = 1'b0;
        arst_n      = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        lfsr        = 32'hdcdca73c;
        checks      = 0;
        errors      = 0;
        mark_checks = 0;
        mark_errors = 0;
        exp_count   = '0;
        exp_flag    = 1'b0;
        exp_result  = '0;
        repeat (4) @(negedge clk);                      // Four posedges in reset
        arst_n = 1'b1;
        @(negedge clk);

        axil_read(5'h10, rd, 0);
        check_value(rd, 32'd0, "status after reset");
        axil_read(5'h0C, rd, 0);
        check_value(rd, 32'd0, "result after reset");
        report_test("reset");

        for (int i = 0; i < 200; i++) begin
            ins = make_op(i % 10);                      // All ten functions in turn
            a   = rand_bits(32);
            b   = (i % 25 == 3) ? a : rand_bits(32);    // Some equal compares
            run_op(ins, a, b);
        end
        report_test("op");

        for (int i = 0; i < 200; i++) begin
            ins = make_opi(i);
            a   = rand_bits(32);
            b   = rand_bits(32);                        // rs2 must not leak in
            run_op(ins, a, b);
        end
        report_test("op_imm");

        a   = rand_bits(32);
        b   = rand_bits(32);
        ins = {25'(rand_bits(25)), 7'b1100011};         // Branch opcode
        run_op(ins, a, b);
        ins = make_op(int'(rand_bits(4)) % 10);
        ins[31:25] = 7'b0000001;                        // M extension encoding
        run_op(ins, a, b);
        for (int i = 0; i < 5; i++) begin
            ins = make_op(i * 2);
            a   = rand_bits(32);
            b   = rand_bits(32);
            run_op(ins, a, b);                          // Flag must stay set
        end
        report_test("illegal");

        for (int i = 0; i < 8; i++) begin
            hold = int'(rand_bits(3)) + 1;
            axil_read(5'h0C, rd, hold);
            check_value(rd, exp_result, "result before ignored writes");
            d = rand_bits(32);
            axil_write(5'h0C, d, hold);                 // Read-only register
            d = rand_bits(32);
            axil_write(5'h14, d, hold);                 // Unmapped
            d = rand_bits(32);
            axil_write(5'h1C, d, hold);
            axil_read(5'h0C, rd, hold);
            check_value(rd, exp_result, "result after ignored writes");
            axil_read(5'h10, rd, hold);
            check_count(rd[31:16], exp_count, "count after ignored writes");
            check_flag(rd[0], exp_flag, "flag after ignored writes");
            axil_read(5'h18, rd, hold);
            check_value(rd, 32'd0, "unmapped read");
        end
        report_test("protocol");

        for (int i = 0; i < 4; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            axil_write(5'h00, a, 0);
            axil_write(5'h04, b, 0);
            for (int k = 0; k < 3; k++) begin
                ins = make_op(int'(rand_bits(4)) % 10);
                axil_write(5'h08, ins, 0);              // No polling in between
            end
            want       = model_op(ins, a, b);
            exp_count  = exp_count + 16'd3;
            exp_result = want.value;
            wait_count(exp_count);
            axil_read(5'h0C, rd, 0);
            check_value(rd, want.value, "result of last back-to-back op");
            axil_read(5'h10, rd, 0);
            check_count(rd[31:16], exp_count, "count after back-to-back ops");
        end
        report_test("b2b");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hdl/rv_alu_pkg.sv
hdl/rv_alu_decode.sv
hdl/rv_alu_execute.sv
hdl/rv_alu_result.sv
hdl/rv_alu_axil_regs.sv
hdl/rv_alu_top.sv
bench/tb_rv_alu_top.sv

// ==== Makefile ====
TOP := tb_rv_alu_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module rv_alu_top
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	! grep -q "SOME TESTS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
